// File: alu.sv
module alu import isaPkg::*, cpuPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  opcodeT opcode,
    input  wordT   opA,
    input  wordT   opB,
    input  logic   flagWrEn,
    output wordT   result,
    output flagsT  flags
);

    wordT       sum;
    wordT       diff;
    logic [3:0] shAmt;
    logic       addOvf;
    logic       subOvf;
    flagsT      flagReg;

    assign sum   = opA + opB;
    assign diff  = opA - opB;
    assign shAmt = opB[3:0];

    // signed overflow, operand signs vs result sign
    assign addOvf = (opA[15] == opB[15]) && (sum[15] != opA[15]);
    assign subOvf = (opA[15] != opB[15]) && (diff[15] != opA[15]);

    always_comb begin
        case (opcode)
            opAdd: result = sum;
            opSub: result = diff;
            opXor: result = opA ^ opB;
            opAnd: result = opA & opB;
            opSll: result = opA << shAmt;
            opSrl: result = opA >> shAmt;
            opSra: result = wordT'($signed(opA) >>> shAmt);
            opOr:  result = opA | opB;
            opLw, opSw: result = sum;                  // base + offset
            opLlb: result = {opA[15:8], opB[7:0]};     // low byte replaced
            opLhb: result = {opB[7:0], opA[7:0]};      // high byte replaced
            default: result = '0;                      // B, BR, PCS, HLT
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagReg <= '0;
        end else if (flagWrEn) begin
            flagReg[flagZ] <= (result == '0);
            // V and N only track add / sub
            if (opcode == opAdd) begin
                flagReg[flagV] <= addOvf;
                flagReg[flagN] <= sum[15];
            end else if (opcode == opSub) begin
                flagReg[flagV] <= subOvf;
                flagReg[flagN] <= diff[15];
            end
        end
    end

    assign flags = flagReg;

    flagsHold: assert property (@(posedge clk) disable iff (!rstN)
        !flagWrEn |=> $stable(flags))
        else $error("flags changed with flagWrEn low");

endmodule

// File: cpu.sv
module cpu import isaPkg::*, cpuPkg::*; (
    input  logic clk,
    input  logic rstN,
    output wordT pc,          // byte address, even
    input  wordT instr,
    output wordT dataAddr,
    output wordT dataWrData,
    input  wordT dataRdData,
    output logic dataRdEn,
    output logic dataWrEn,
    output logic hlt
);

    opcodeT     opcode;
    regIdxT     fieldA, fieldB, fieldC;
    logic [7:0] imm8;
    regIdxT     rdAddrA, rdAddrB;
    wordT       rdDataA, rdDataB;
    wordT       immExt;
    wordT       aluOpB;
    wordT       aluResult;
    wordT       wrData;
    wordT       pcPlus2;
    flagsT      flags;
    logic       isMem;
    logic       regWrEn, memToReg, pcToReg, aluSrcImm, byteLoad;
    logic       flagWrEn, branchImm, branchReg, haltNow;

    // instruction fields
    assign opcode = instr[opcodeMsb:opcodeLsb];
    assign fieldA = instr[fieldAMsb:fieldALsb];
    assign fieldB = instr[fieldBMsb:fieldBLsb];
    assign fieldC = instr[fieldCMsb:fieldCLsb];
    assign imm8   = instr[imm8Msb:0];
    assign isMem  = (opcode == opLw) || (opcode == opSw);

    assign rdAddrA = byteLoad ? fieldA : fieldB;          // byte loads merge into rd
    assign rdAddrB = (opcode == opSw) ? fieldA : fieldC;  // store data on port B

    // LW/SW offset signed and doubled, LLB/LHB imm8, shifts fieldC
    always_comb begin
        if (isMem)         immExt = {{11{fieldC[3]}}, fieldC, 1'b0};
        else if (byteLoad) immExt = {8'h00, imm8};
        else               immExt = {12'h000, fieldC};
    end

    assign aluOpB = aluSrcImm ? immExt : rdDataB;

    // write-back mux
    assign wrData = pcToReg  ? pcPlus2 :
                    memToReg ? dataRdData : aluResult;

    assign dataAddr   = aluResult;
    assign dataWrData = rdDataB;

    cpuControl uCtrl (
        .clk(clk), .rstN(rstN), .instr(instr),
        .regWrEn(regWrEn), .memToReg(memToReg), .pcToReg(pcToReg),
        .aluSrcImm(aluSrcImm), .byteLoad(byteLoad),
        .dataRdEn(dataRdEn), .dataWrEn(dataWrEn), .flagWrEn(flagWrEn),
        .branchImm(branchImm), .branchReg(branchReg),
        .haltNow(haltNow), .hlt(hlt)
    );

    pcUnit uPc (
        .clk(clk), .rstN(rstN), .instr(instr), .flags(flags),
        .regTarget(rdDataA), // fieldB register for BR
        .branchImm(branchImm), .branchReg(branchReg),
        .haltNow(haltNow), .hlt(hlt),
        .pc(pc), .pcPlus2(pcPlus2)
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(fieldA),
        .wrEn(regWrEn), .wrData(wrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    alu uAlu (
        .clk(clk), .rstN(rstN), .opcode(opcode),
        .opA(rdDataA), .opB(aluOpB), .flagWrEn(flagWrEn),
        .result(aluResult), .flags(flags)
    );

endmodule

// File: cpuControl.sv
module cpuControl import isaPkg::*, cpuPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  wordT instr,
    output logic regWrEn,   // write-back to fieldA
    output logic memToReg,  // write-back from data memory
    output logic pcToReg,   // write-back of pc + 2
    output logic aluSrcImm, // second alu operand is the immediate
    output logic byteLoad,  // LLB / LHB
    output logic dataRdEn,
    output logic dataWrEn,
    output logic flagWrEn,
    output logic branchImm, // B
    output logic branchReg, // BR
    output logic haltNow,   // HLT on instr this cycle
    output logic hlt        // registered halt state
);

    opcodeT   opcode;
    runStateT state;
    logic     isAluOp;
    logic     running;

    assign opcode  = instr[opcodeMsb:opcodeLsb];
    assign isAluOp = !opcode[3]; // opcodes 0..7
    assign running = (state == RUN);

    // decode, writes masked once halted
    assign regWrEn   = running && (isAluOp || opcode == opLw || opcode == opLlb
                                   || opcode == opLhb || opcode == opPcs);
    assign flagWrEn  = running && isAluOp;
    assign dataRdEn  = running && (opcode == opLw);
    assign dataWrEn  = running && (opcode == opSw);
    assign memToReg  = (opcode == opLw);
    assign pcToReg   = (opcode == opPcs);
    assign byteLoad  = (opcode == opLlb) || (opcode == opLhb);
    // shifts take fieldC as amount, mem ops take the offset, byte loads imm8
    assign aluSrcImm = (opcode == opSll) || (opcode == opSrl) || (opcode == opSra)
                       || (opcode == opLw) || (opcode == opSw) || byteLoad;
    assign branchImm = (opcode == opB);
    assign branchReg = (opcode == opBr);
    assign haltNow   = (opcode == opHlt);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= RUN;
        end else if (running && haltNow) begin
            state <= HALTED; // sticky until reset
        end
    end

    assign hlt = (state == HALTED); // one cycle behind HLT on instr

    // a memory access is either a read or a write
    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(dataRdEn && dataWrEn))
        else $error("dataRdEn and dataWrEn both high");

    // only reset brings the core back out of halt
    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        hlt |=> hlt)
        else $error("hlt fell without reset");

endmodule

// File: cpuPkg.sv
package cpuPkg;

    typedef logic [15:0] wordT;  // data word or byte address
    typedef logic [3:0]  regIdxT; // register number
    typedef logic [2:0]  flagsT;  // {Z, V, N}

    localparam int numRegs = 16;

    // positions inside flagsT
    localparam int flagZ = 2;
    localparam int flagV = 1;
    localparam int flagN = 0;

    // core run state, HALTED is left only by reset
    typedef enum logic {
        RUN,
        HALTED
    } runStateT;

endpackage

// File: isaPkg.sv
package isaPkg;

    typedef logic [3:0] opcodeT; // instr[15:12]
    typedef logic [2:0] condT;   // instr[11:9] on B / BR

    // alu group, opcode msb clear
    localparam opcodeT opAdd = 4'h0;
    localparam opcodeT opSub = 4'h1;
    localparam opcodeT opXor = 4'h2;
    localparam opcodeT opAnd = 4'h3;
    localparam opcodeT opSll = 4'h4;
    localparam opcodeT opSrl = 4'h5;
    localparam opcodeT opSra = 4'h6;
    localparam opcodeT opOr  = 4'h7;
    // memory, byte load, flow control
    localparam opcodeT opLw  = 4'h8;
    localparam opcodeT opSw  = 4'h9;
    localparam opcodeT opLlb = 4'ha;
    localparam opcodeT opLhb = 4'hb;
    localparam opcodeT opB   = 4'hc;
    localparam opcodeT opBr  = 4'hd;
    localparam opcodeT opPcs = 4'he;
    localparam opcodeT opHlt = 4'hf;

    localparam condT condNe     = 3'd0; // Z clear
    localparam condT condEq     = 3'd1; // Z set
    localparam condT condGt     = 3'd2; // Z and N clear
    localparam condT condLt     = 3'd3; // N set
    localparam condT condGe     = 3'd4; // Z set or N clear
    localparam condT condLe     = 3'd5; // Z or N set
    localparam condT condOv     = 3'd6; // V set
    localparam condT condAlways = 3'd7;

    // bit positions inside the instruction word
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 12;
    localparam int fieldAMsb = 11;
    localparam int fieldALsb = 8;
    localparam int fieldBMsb = 7;
    localparam int fieldBLsb = 4;
    localparam int fieldCMsb = 3;
    localparam int fieldCLsb = 0;
    localparam int condMsb   = 11;
    localparam int condLsb   = 9;
    localparam int imm8Msb   = 7;  // imm8 starts at bit 0
    localparam int imm9Msb   = 8;  // imm9 likewise

endpackage

// File: list.f
isaPkg.sv
cpuPkg.sv
cpuControl.sv
pcUnit.sv
regFile.sv
alu.sv
cpu.sv
tb_cpu.sv

// File: pcUnit.sv
module pcUnit import isaPkg::*, cpuPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  wordT  instr,
    input  flagsT flags,
    input  wordT  regTarget, // fieldB register, for BR
    input  logic  branchImm,
    input  logic  branchReg,
    input  logic  haltNow,
    input  logic  hlt,
    output wordT  pc,
    output wordT  pcPlus2
);

    condT       cond;
    logic [8:0] imm9;
    wordT       immTarget;
    wordT       pcNext;
    logic       condMet;
    logic       zf, vf, nf;

    assign cond = instr[condMsb:condLsb];
    assign imm9 = instr[imm9Msb:0];
    assign zf   = flags[flagZ];
    assign vf   = flags[flagV];
    assign nf   = flags[flagN];

    always_comb begin
        case (cond)
            condNe:  condMet = !zf;
            condEq:  condMet = zf;
            condGt:  condMet = !zf && !nf;
            condLt:  condMet = nf;
            condGe:  condMet = zf || !nf;
            condLe:  condMet = zf || nf;
            condOv:  condMet = vf;
            default: condMet = 1'b1; // condAlways
        endcase
    end

    assign pcPlus2   = pc + 16'd2;
    assign immTarget = pcPlus2 + {{6{imm9[8]}}, imm9, 1'b0}; // word offset, doubled

    always_comb begin
        if (haltNow || hlt)
            pcNext = pc; // freeze on HLT
        else if (branchImm && condMet)
            pcNext = immTarget;
        else if (branchReg && condMet)
            pcNext = {regTarget[15:1], 1'b0}; // keep pc on a word boundary
        else
            pcNext = pcPlus2;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) pc <= '0;
        else       pc <= pcNext;
    end

    pcEven: assert property (@(posedge clk) disable iff (!rstN) !pc[0])
        else $error("odd pc %h", pc);

    pcHeld: assert property (@(posedge clk) disable iff (!rstN) hlt |=> $stable(pc))
        else $error("pc moved while halted");

endmodule

// File: regFile.sv
module regFile import cpuPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rdAddrA,
    input  regIdxT rdAddrB,
    input  regIdxT wrAddr,
    input  logic   wrEn,
    input  wordT   wrData,
    output wordT   rdDataA,
    output wordT   rdDataB
);

    wordT regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData; // r0 never written so it reads zero
        end
    end

    // plain async reads with no bypass since the write lands at the retiring edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and grep the log for the pass line
verilator --binary --assert -j 0 --top-module tb_cpu -f list.f -o tb_cpu > build.log 2>&1 \
    && ./obj_dir/tb_cpu > sim.log 2>&1 \
    && grep -q "All tests passed" sim.log \
    && echo PASS || { echo FAIL; exit 1; }

// File: tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numTests   = 5;
    localparam int progLen    = 64;
    localparam int haltCycles = 20;
    localparam int cycleLimit = numTests * (progLen * 4 + 20); // 1380
    localparam logic [3:0] memOps [5] = '{4'ha, 4'hb, 4'h0, 4'h8, 4'h9}; // LLB LHB ADD LW SW

    logic        clk;
    logic        rstN;
    logic [15:0] pc, instr, dataAddr, dataWrData, dataRdData;
    logic        dataRdEn, dataWrEn, hlt;
    logic [15:0] imem [128];
    logic [15:0] dmem [128];
    logic [15:0] mRegs [16]; // reference model state
    logic [15:0] mMem [128];
    logic [15:0] mPc;
    logic        mZ, mV, mN, mHalted;
    int          errors = 0;
    int          testErrors, failedTests;
    int          cycles = 0;
    string       testNames [numTests] = '{"reset", "alu", "mem", "branch", "halt"};

    cpu u_cpu (
        .clk(clk), .rstN(rstN), .pc(pc), .instr(instr),
        .dataAddr(dataAddr), .dataWrData(dataWrData), .dataRdData(dataRdData),
        .dataRdEn(dataRdEn), .dataWrEn(dataWrEn), .hlt(hlt)
    );

    assign instr      = imem[pc[7:1]];       // combinational fetch
    assign dataRdData = dmem[dataAddr[7:1]]; // byte address into the word array

    always @(posedge clk) begin
        if (dataWrEn) dmem[dataAddr[7:1]] <= dataWrData;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("run hung, no halt within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            testErrors++;
        end
    endtask

    function automatic logic condHolds(input logic [2:0] cond);
        case (cond)
            3'd0: return !mZ;
            3'd1: return mZ;
            3'd2: return !mZ && !mN;
            3'd3: return mN;
            3'd4: return mZ || !mN;
            3'd5: return mZ || mN;
            3'd6: return mV;
            default: return 1'b1; // always
        endcase
    endfunction

    // compare this cycle's outputs and then retire the instr in the model
    task automatic modelStep();
        logic [15:0] ins, x, y, res, addr, nextPc;
        logic [3:0]  opc, a, c;
        int          wide;
        ins    = imem[mPc[7:1]];
        opc    = ins[15:12];
        a      = ins[11:8];
        c      = ins[3:0];
        x      = mRegs[ins[7:4]];
        y      = mRegs[c];
        addr   = x + {{11{c[3]}}, c, 1'b0}; // offset in words
        res    = mRegs[a];                  // old value that byte loads merge into
        nextPc = mPc + 16'd2;
        check("pc", mPc, pc);
        check("hlt", 16'(mHalted), 16'(hlt));
        check("dataRdEn", 16'(!mHalted && opc == 4'h8), 16'(dataRdEn));
        check("dataWrEn", 16'(!mHalted && opc == 4'h9), 16'(dataWrEn));
        if (mHalted) return;
        if (opc == 4'h8 || opc == 4'h9) check("dataAddr", addr, dataAddr);
        if (opc == 4'h9) begin
            check("dataWrData", mRegs[a], dataWrData);
            mMem[addr[7:1]] = mRegs[a];
        end
        case (opc)
            4'h0, 4'h1: begin
                if (opc == 4'h0) wide = int'($signed(x)) + int'($signed(y));
                else wide = int'($signed(x)) - int'($signed(y));
                res = wide[15:0];
                mV  = wide > 32767 || wide < -32768; // out of 16-bit signed range
                mN  = res[15];
            end
            4'h2: res = x ^ y;
            4'h3: res = x & y;
            4'h4: res = x << c;
            4'h5: res = x >> c;
            4'h6: res = $signed(x) >>> c;
            4'h7: res = x | y;
            4'h8: res = mMem[addr[7:1]];
            4'ha: res = {res[15:8], ins[7:0]};
            4'hb: res = {ins[7:0], res[7:0]};
            4'hc: if (condHolds(ins[11:9])) nextPc = nextPc + {{6{ins[8]}}, ins[8:0], 1'b0};
            4'hd: if (condHolds(ins[11:9])) nextPc = x;
            4'he: res = mPc + 16'd2;
            4'hf: begin
                mHalted = 1'b1;
                nextPc  = mPc; // parked on HLT
            end
            default: ;
        endcase
        if (!opc[3]) mZ = (res == 16'h0);
        if (a != 4'h0 && (opc <= 4'h8 || opc == 4'ha || opc == 4'hb || opc == 4'he))
            mRegs[a] = res; // r0 writes dropped
        mPc = nextPc;
    endtask

    task automatic loadProgram(input int kind);
        logic [15:0] r;
        int          m, blk;
        for (int i = 0; i < 128; i++) begin
            imem[i] = {4'hf, 12'(i)};                 // HLT with the address in spare bits
            dmem[i] = 16'h5a00 ^ (16'(i) * 16'h0107); // every word distinct
            mMem[i] = dmem[i];
        end
        for (int i = 0; i < progLen - 1; i++) begin
            r   = 16'($urandom);
            blk = i / 4;
            if (kind == 1 && i % 2 == 1) begin
                imem[i] = {4'h9, imem[i - 1][11:8], 4'h0, r[3:0]}; // store last result
            end else if (kind == 1) begin
                m       = int'($urandom % 10);
                imem[i] = {4'(m < 8 ? m : m + 2), r[11:0]};     // alu op, LLB or LHB
            end else if (kind == 2) begin
                imem[i] = {memOps[3'($urandom % 5)], r[11:0]};
            end else if (kind == 3) begin
                // 4-slot blocks where branches only land on a block start
                if (i >= 60 || i % 4 == 0 || (i % 4 == 3 && imem[i - 1][15:12] == 4'hc))
                    imem[i] = {1'b0, r[14:12], 4'($urandom % 15), r[7:0]}; // r15 untouched
                else if (i % 4 == 1)
                    imem[i] = {4'he, 4'($urandom % 15), r[7:0]};
                else if (i % 4 == 3)
                    imem[i] = {4'hd, r[11:9], 1'b0, 4'hf, 4'h0}; // BR through r15
                else begin
                    m = blk + 1 + int'($urandom % 32'(15 - blk)); // later block
                    if (r[0]) imem[i] = {4'hc, r[11:9], 9'(4 * m - i - 1)};
                    else imem[i] = {4'ha, 4'hf, 8'(8 * m)}; // r15 low byte = target
                end
            end else begin
                imem[i] = {4'($urandom % 12), r[11:0]}; // no flow control
            end
        end
        if (kind == 4) imem[8 + int'($urandom % 32)] = 16'hf000; // early halt so the tail never runs
        if (imem[0][15:12] == 4'h9) imem[0][15:12] = 4'h3; // slot 0 sits on instr during reset
        for (int i = 0; i < 16; i++) mRegs[i] = 16'h0;
        {mZ, mV, mN, mHalted} = 4'b0000;
        mPc = 16'h0;
    endtask

    initial begin
        int haltSeen;
        void'($urandom(32'h6c1b));
        failedTests = 0;
        for (int t = 0; t < numTests; t++) begin
            testErrors = 0;
            rstN = 1'b0;
            loadProgram(t);
            repeat (3) begin
                @(negedge clk);
                check("pc", 16'h0, pc);
                check("hlt", 16'h0, 16'(hlt));
                check("dataWrEn", 16'h0, 16'(dataWrEn));
            end
            rstN     = 1'b1;
            haltSeen = 0;
            while (haltSeen < haltCycles) begin
                if (mHalted) haltSeen++;
                modelStep();
                @(negedge clk);
            end
            $display("test %0d %s: %s, %0d errors", t, testNames[t],
                     testErrors == 0 ? "pass" : "FAIL", testErrors);
            errors += testErrors;
            if (testErrors != 0) failedTests++;
        end
        $display("%0d tests, %0d failed, %0d errors", numTests, failedTests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
